// File: Bender.yml
package:
  name: rv_decode

sources:
  - rv_isa_pkg.sv
  - rv_decode_pkg.sv
  - rv_inst_classify.sv
  - rv_imm_gen.sv
  - rv_decode_stage.sv
  - rv_decode.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_rv_decode.sv

// File: files.f
+incdir+.
rv_isa_pkg.sv
rv_decode_pkg.sv
rv_inst_classify.sv
rv_imm_gen.sv
rv_decode_stage.sv
rv_decode.sv
tb_rv_decode.sv

// File: rv_decode.sv
`timescale 1ns/1ps

module rv_decode #(
    parameter int PC_W = 32
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_valid,
    input  rv_decode_pkg::fetch_bus_t  i_fetch,
    output rv_decode_pkg::decode_bus_t o_dec
);

    rv_isa_pkg::inst_e inst;
    logic [4:0]        rd;
    logic [4:0]        rs1;
    logic [4:0]        rs2;
    logic [2:0]        funct3;
    logic [31:0]       imm_i;
    logic [31:0]       imm_j;

    rv_inst_classify u_classify (
        .i_valid  (i_valid),
        .i_instr  (i_fetch.instruction),
        .o_inst   (inst),
        .o_rd     (rd),
        .o_rs1    (rs1),
        .o_rs2    (rs2),
        .o_funct3 (funct3)
    );

    rv_imm_gen u_imm_gen (
        .i_instr (i_fetch.instruction),
        .i_inst  (inst),
        .o_imm_i (imm_i),
        .o_imm_j (imm_j)
    );

    rv_decode_stage #(
        .PC_W (PC_W)
    ) u_stage (
        .i_clk    (i_clk),
        .i_rst    (i_rst),
        .i_valid  (i_valid),
        .i_inst   (inst),
        .i_rd     (rd),
        .i_rs1    (rs1),
        .i_rs2    (rs2),
        .i_funct3 (funct3),
        .i_imm_i  (imm_i),
        .i_imm_j  (imm_j),
        .i_pc     (i_fetch.pc[PC_W-1:0]), // low bits only when PC_W is narrower
        .o_dec    (o_dec)
    );

endmodule

// File: rv_decode_pkg.sv
package rv_decode_pkg;

    typedef struct packed {
        logic [31:0] instruction;
        logic [31:0] pc;
    } fetch_bus_t;

    typedef struct packed {
        // result group
        logic res_cmp;
        logic res_bits;
        logic res_shift;
        logic res_arith;
        // operation within the group
        logic cmp_eq;
        logic cmp_lts;
        logic cmp_ltu;
        logic cmp_inversed;
        logic bits_and;
        logic bits_or;
        logic bits_xor;
        logic arith_shl;
        logic arith_shr;
        logic arith_sub;
        logic arith_add;
        logic shift_arithmetical; // srai and sra only
    } alu_ctrl_t;

    typedef struct packed {
        logic pc;
        logic r;
    } op1_src_t;

    typedef struct packed {
        logic j;
        logic i;
        logic r;
    } op2_src_t;

    typedef struct packed {
        logic memory;
        logic pc_p4; // link address for jal and jalr
        logic alu;
    } res_src_t;

    typedef struct packed {
        logic        valid;
        logic        inst_supported;
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [31:0] imm_i;
        logic [31:0] imm_j;
        logic [2:0]  funct3;
        alu_ctrl_t   alu_ctrl;
        op1_src_t    op1_src;
        op2_src_t    op2_src;
        res_src_t    res_src;
        logic        reg_write;
        logic        inst_jalr;
        logic        inst_jal;
        logic        inst_branch;
        logic        inst_store;
        logic [31:0] pc;
    } decode_bus_t;

endpackage

// File: rv_decode_stage.sv
`timescale 1ns/1ps

module rv_decode_stage #(
    parameter int PC_W = 32
) (
    input  logic                       i_clk,
    input  logic                       i_rst,
    input  logic                       i_valid,
    input  rv_isa_pkg::inst_e          i_inst,
    input  logic [4:0]                 i_rd,
    input  logic [4:0]                 i_rs1,
    input  logic [4:0]                 i_rs2,
    input  logic [2:0]                 i_funct3,
    input  logic [31:0]                i_imm_i,
    input  logic [31:0]                i_imm_j,
    input  logic [PC_W-1:0]            i_pc,
    output rv_decode_pkg::decode_bus_t o_dec
);

    rv_decode_pkg::decode_bus_t dec_d;
    rv_decode_pkg::alu_ctrl_t   alu;
    logic is_load;
    logic is_store;
    logic is_imm;
    logic is_reg;
    logic is_branch;
    logic is_lui;
    logic is_auipc;
    logic is_jal;
    logic is_jalr;
    logic use_imm;

    assign is_load   = i_inst inside {[rv_isa_pkg::INST_LB : rv_isa_pkg::INST_LHU]};
    assign is_store  = i_inst inside {[rv_isa_pkg::INST_SB : rv_isa_pkg::INST_SW]};
    assign is_imm    = i_inst inside {[rv_isa_pkg::INST_ADDI : rv_isa_pkg::INST_SRAI]};
    assign is_reg    = i_inst inside {[rv_isa_pkg::INST_ADD : rv_isa_pkg::INST_AND]};
    assign is_branch = i_inst inside {[rv_isa_pkg::INST_BEQ : rv_isa_pkg::INST_BGEU]};
    assign is_lui    = (i_inst == rv_isa_pkg::INST_LUI);
    assign is_auipc  = (i_inst == rv_isa_pkg::INST_AUIPC);
    assign is_jal    = (i_inst == rv_isa_pkg::INST_JAL);
    assign is_jalr   = (i_inst == rv_isa_pkg::INST_JALR);
    assign use_imm   = is_jalr | is_load | is_imm | is_lui | is_auipc | is_store;

    always_comb begin
        alu = '0;
        case (i_inst) inside
            [rv_isa_pkg::INST_LB : rv_isa_pkg::INST_SW], rv_isa_pkg::INST_ADD,
            rv_isa_pkg::INST_ADDI: begin
                alu.res_arith = 1'b1; // address calc for loads and stores
                alu.arith_add = 1'b1;
            end
            rv_isa_pkg::INST_SUB: begin
                alu.res_arith = 1'b1;
                alu.arith_sub = 1'b1;
            end
            rv_isa_pkg::INST_BEQ, rv_isa_pkg::INST_BNE: begin
                alu.res_cmp = 1'b1;
                alu.cmp_eq  = 1'b1;
            end
            rv_isa_pkg::INST_SLT, rv_isa_pkg::INST_SLTI,
            rv_isa_pkg::INST_BLT, rv_isa_pkg::INST_BGE: begin
                alu.res_cmp = 1'b1;
                alu.cmp_lts = 1'b1;
            end
            rv_isa_pkg::INST_SLTU, rv_isa_pkg::INST_SLTIU,
            rv_isa_pkg::INST_BLTU, rv_isa_pkg::INST_BGEU: begin
                alu.res_cmp = 1'b1;
                alu.cmp_ltu = 1'b1;
            end
            rv_isa_pkg::INST_AND, rv_isa_pkg::INST_ANDI: begin
                alu.res_bits = 1'b1;
                alu.bits_and = 1'b1;
            end
            rv_isa_pkg::INST_OR, rv_isa_pkg::INST_ORI: begin
                alu.res_bits = 1'b1;
                alu.bits_or  = 1'b1;
            end
            rv_isa_pkg::INST_XOR, rv_isa_pkg::INST_XORI: begin
                alu.res_bits = 1'b1;
                alu.bits_xor = 1'b1;
            end
            rv_isa_pkg::INST_SLL, rv_isa_pkg::INST_SLLI: begin
                alu.res_shift = 1'b1;
                alu.arith_shl = 1'b1;
            end
            rv_isa_pkg::INST_SRL, rv_isa_pkg::INST_SRLI: begin
                alu.res_shift = 1'b1;
                alu.arith_shr = 1'b1;
            end
            rv_isa_pkg::INST_SRA, rv_isa_pkg::INST_SRAI: begin
                alu.res_shift          = 1'b1;
                alu.arith_shr          = 1'b1;
                alu.shift_arithmetical = 1'b1;
            end
            default: ;
        endcase
        alu.cmp_inversed = is_branch & i_funct3[0]; // bne, bge, bgeu
    end

    always_comb begin
        dec_d.valid          = i_valid;
        dec_d.inst_supported = (i_inst != rv_isa_pkg::INST_BAD);
        dec_d.rd             = i_rd;
        dec_d.rs1            = i_rs1;
        dec_d.rs2            = i_rs2;
        dec_d.imm_i          = i_imm_i;
        dec_d.imm_j          = i_imm_j;
        dec_d.funct3         = i_funct3;
        dec_d.alu_ctrl       = alu;
        dec_d.op1_src.pc     = is_auipc | is_jal;
        dec_d.op1_src.r      = !(is_auipc | is_jal);
        dec_d.op2_src.j      = is_jal;
        dec_d.op2_src.i      = use_imm;
        dec_d.op2_src.r      = !(is_jal | use_imm);
        dec_d.res_src.memory = is_load;
        dec_d.res_src.pc_p4  = is_jal | is_jalr;
        dec_d.res_src.alu    = !(is_load | is_jal | is_jalr);
        dec_d.reg_write      = is_load | is_imm | is_reg | is_lui | is_auipc | is_jal | is_jalr;
        dec_d.inst_jalr      = is_jalr;
        dec_d.inst_jal       = is_jal;
        dec_d.inst_branch    = is_branch;
        dec_d.inst_store     = is_store;
        dec_d.pc             = 32'(i_pc); // zero extended
    end

    always_ff @(posedge i_clk) begin
        o_dec <= dec_d;
        if (i_rst) begin // payload fields keep loading
            o_dec.valid          <= 1'b0;
            o_dec.inst_supported <= 1'b0;
            o_dec.alu_ctrl       <= '0;
            o_dec.op1_src        <= '0;
            o_dec.op2_src        <= '0;
            o_dec.res_src        <= '0;
            o_dec.reg_write      <= 1'b0;
            o_dec.inst_jalr      <= 1'b0;
            o_dec.inst_jal       <= 1'b0;
            o_dec.inst_branch    <= 1'b0;
            o_dec.inst_store     <= 1'b0;
        end
    end

    // write-back only ever comes from a valid word the classifier accepted
    assert property (@(posedge i_clk) disable iff (i_rst)
        o_dec.reg_write |-> (o_dec.valid && o_dec.inst_supported))
        else $error("reg_write set without a valid supported instruction");

endmodule

// File: rv_imm_gen.sv
`timescale 1ns/1ps

module rv_imm_gen (
    input  logic [31:0]       i_instr,
    input  rv_isa_pkg::inst_e i_inst,
    output logic [31:0]       o_imm_i,
    output logic [31:0]       o_imm_j
);

    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic        is_u;
    logic        is_s;

    assign imm_i = {{21{i_instr[31]}}, i_instr[30:20]};
    assign imm_s = {{21{i_instr[31]}}, i_instr[30:25], i_instr[11:7]};
    assign imm_b = {{20{i_instr[31]}}, i_instr[7], i_instr[30:25], i_instr[11:8], 1'b0};
    assign imm_u = {i_instr[31:12], 12'b0};
    assign imm_j = {{12{i_instr[31]}}, i_instr[19:12], i_instr[20], i_instr[30:21], 1'b0};

    assign is_u = (i_inst == rv_isa_pkg::INST_LUI) || (i_inst == rv_isa_pkg::INST_AUIPC);
    assign is_s = i_inst inside {[rv_isa_pkg::INST_SB : rv_isa_pkg::INST_SW]};

    assign o_imm_i = is_u ? imm_u : (is_s ? imm_s : imm_i);
    assign o_imm_j = (i_inst == rv_isa_pkg::INST_JAL) ? imm_j : imm_b; // branch offset otherwise

    always_comb begin
        if (is_u) begin
            assert final (o_imm_i[11:0] == 12'b0)
                else $error("upper immediate with nonzero low bits: %h", o_imm_i);
        end
    end

endmodule

// File: rv_inst_classify.sv
`timescale 1ns/1ps

module rv_inst_classify (
    input  logic              i_valid,
    input  logic [31:0]       i_instr,
    output rv_isa_pkg::inst_e o_inst,
    output logic [4:0]        o_rd,
    output logic [4:0]        o_rs1,
    output logic [4:0]        o_rs2,
    output logic [2:0]        o_funct3
);

    rv_isa_pkg::opcode_e opcode;
    logic [2:0]          funct3;
    logic [6:0]          funct7;
    logic                base_f7;
    logic                alt_f7;

    assign opcode  = rv_isa_pkg::opcode_e'(i_instr[6:2]);
    assign funct3  = i_instr[14:12];
    assign funct7  = i_instr[31:25];
    assign base_f7 = (funct7 == rv_isa_pkg::F7_BASE);
    assign alt_f7  = (funct7 == rv_isa_pkg::F7_ALT);

    always_comb begin
        o_inst = rv_isa_pkg::INST_BAD; // anything unmatched
        if (!i_valid || i_instr == '0) begin
            o_inst = rv_isa_pkg::INST_NONE;
        end else if (i_instr[1:0] == rv_isa_pkg::OPC_FULL) begin
            case (opcode)
                rv_isa_pkg::OPC_LOAD: begin
                    case (funct3)
                        3'b000: o_inst = rv_isa_pkg::INST_LB;
                        3'b001: o_inst = rv_isa_pkg::INST_LH;
                        3'b010: o_inst = rv_isa_pkg::INST_LW;
                        3'b100: o_inst = rv_isa_pkg::INST_LBU;
                        3'b101: o_inst = rv_isa_pkg::INST_LHU;
                        default: ;
                    endcase
                end
                rv_isa_pkg::OPC_STORE: begin
                    case (funct3)
                        3'b000: o_inst = rv_isa_pkg::INST_SB;
                        3'b001: o_inst = rv_isa_pkg::INST_SH;
                        3'b010: o_inst = rv_isa_pkg::INST_SW;
                        default: ;
                    endcase
                end
                rv_isa_pkg::OPC_OP_IMM: begin
                    case (funct3)
                        3'b000: o_inst = rv_isa_pkg::INST_ADDI;
                        3'b010: o_inst = rv_isa_pkg::INST_SLTI;
                        3'b011: o_inst = rv_isa_pkg::INST_SLTIU;
                        3'b100: o_inst = rv_isa_pkg::INST_XORI;
                        3'b110: o_inst = rv_isa_pkg::INST_ORI;
                        3'b111: o_inst = rv_isa_pkg::INST_ANDI;
                        3'b001: begin
                            if (base_f7) o_inst = rv_isa_pkg::INST_SLLI;
                        end
                        default: begin // 3'b101
                            if (base_f7) o_inst = rv_isa_pkg::INST_SRLI;
                            else if (alt_f7) o_inst = rv_isa_pkg::INST_SRAI;
                        end
                    endcase
                end
                rv_isa_pkg::OPC_OP: begin
                    if (base_f7) begin
                        case (funct3)
                            3'b000: o_inst = rv_isa_pkg::INST_ADD;
                            3'b001: o_inst = rv_isa_pkg::INST_SLL;
                            3'b010: o_inst = rv_isa_pkg::INST_SLT;
                            3'b011: o_inst = rv_isa_pkg::INST_SLTU;
                            3'b100: o_inst = rv_isa_pkg::INST_XOR;
                            3'b101: o_inst = rv_isa_pkg::INST_SRL;
                            3'b110: o_inst = rv_isa_pkg::INST_OR;
                            default: o_inst = rv_isa_pkg::INST_AND;
                        endcase
                    end else if (alt_f7 && funct3 == 3'b000) begin
                        o_inst = rv_isa_pkg::INST_SUB;
                    end else if (alt_f7 && funct3 == 3'b101) begin
                        o_inst = rv_isa_pkg::INST_SRA;
                    end
                end
                rv_isa_pkg::OPC_BRANCH: begin
                    case (funct3)
                        3'b000: o_inst = rv_isa_pkg::INST_BEQ;
                        3'b001: o_inst = rv_isa_pkg::INST_BNE;
                        3'b100: o_inst = rv_isa_pkg::INST_BLT;
                        3'b101: o_inst = rv_isa_pkg::INST_BGE;
                        3'b110: o_inst = rv_isa_pkg::INST_BLTU;
                        3'b111: o_inst = rv_isa_pkg::INST_BGEU;
                        default: ;
                    endcase
                end
                rv_isa_pkg::OPC_MISC_MEM: begin
                    if (funct3 == 3'b000) o_inst = rv_isa_pkg::INST_FENCE;
                    else if (funct3 == 3'b001) o_inst = rv_isa_pkg::INST_FENCE_I;
                end
                rv_isa_pkg::OPC_JALR: begin
                    if (funct3 == 3'b000) o_inst = rv_isa_pkg::INST_JALR;
                end
                rv_isa_pkg::OPC_JAL:   o_inst = rv_isa_pkg::INST_JAL;
                rv_isa_pkg::OPC_LUI:   o_inst = rv_isa_pkg::INST_LUI;
                rv_isa_pkg::OPC_AUIPC: o_inst = rv_isa_pkg::INST_AUIPC;
                default: ; // system and reserved opcodes
            endcase
        end
    end

    assign o_rd     = i_instr[11:7];
    assign o_rs1    = (o_inst == rv_isa_pkg::INST_LUI) ? 5'd0 : i_instr[19:15];
    assign o_rs2    = i_instr[24:20];
    assign o_funct3 = funct3;

    // compressed-looking words are rejected, never decoded as something else
    always_comb begin
        if (i_valid && i_instr != '0 && i_instr[1:0] != rv_isa_pkg::OPC_FULL) begin
            assert final (o_inst == rv_isa_pkg::INST_BAD)
                else $error("16-bit word not reported unsupported: %h", i_instr);
        end
    end

endmodule

// File: rv_isa_pkg.sv
package rv_isa_pkg;

    // major opcode, instruction bits 6:2
    typedef enum logic [4:0] {
        OPC_LOAD     = 5'b00000,
        OPC_MISC_MEM = 5'b00011,
        OPC_OP_IMM   = 5'b00100,
        OPC_AUIPC    = 5'b00101,
        OPC_STORE    = 5'b01000,
        OPC_OP       = 5'b01100,
        OPC_LUI      = 5'b01101,
        OPC_BRANCH   = 5'b11000,
        OPC_JALR     = 5'b11001,
        OPC_JAL      = 5'b11011,
        OPC_SYSTEM   = 5'b11100
    } opcode_e;

    localparam logic [1:0] OPC_FULL = 2'b11; // bits 1:0 of every 32-bit word

    localparam logic [6:0] F7_BASE = 7'b0000000;
    localparam logic [6:0] F7_ALT  = 7'b0100000; // sub, sra, srai

    // each class is kept contiguous, ranges are used by the decoder
    typedef enum logic [5:0] {
        INST_NONE,
        INST_BAD,
        INST_LB,
        INST_LH,
        INST_LW,
        INST_LBU,
        INST_LHU,
        INST_SB,
        INST_SH,
        INST_SW,
        INST_ADDI,
        INST_SLTI,
        INST_SLTIU,
        INST_XORI,
        INST_ORI,
        INST_ANDI,
        INST_SLLI,
        INST_SRLI,
        INST_SRAI,
        INST_ADD,
        INST_SUB,
        INST_SLL,
        INST_SLT,
        INST_SLTU,
        INST_XOR,
        INST_SRL,
        INST_SRA,
        INST_OR,
        INST_AND,
        INST_BEQ,
        INST_BNE,
        INST_BLT,
        INST_BGE,
        INST_BLTU,
        INST_BGEU,
        INST_LUI,
        INST_AUIPC,
        INST_JAL,
        INST_JALR,
        INST_FENCE,
        INST_FENCE_I
    } inst_e;

endpackage

// File: tb_rv_decode_model.svh
`ifndef TB_RV_DECODE_MODEL_SVH
`define TB_RV_DECODE_MODEL_SVH

// word layout {funct7, rs2, rs1, funct3, rd, opcode, 2'b11}; immediates ride in the same bits
function automatic logic [31:0] encode_word(input logic [6:0] f7, input logic [4:0] rs2,
                                            input logic [4:0] rs1, input logic [2:0] f3,
                                            input logic [4:0] rd, input logic [4:0] opc);
    return {f7, rs2, rs1, f3, rd, opc, rv_isa_pkg::OPC_FULL};
endfunction

// expected registered bundle for one sampled input
function automatic rv_decode_pkg::decode_bus_t predict_decode(input logic v,
                                                              input logic [31:0] w,
                                                              input logic [31:0] pc);
    rv_decode_pkg::decode_bus_t e;
    logic [4:0] op;
    logic [2:0] f3;
    logic [6:0] f7;
    logic       full;
    logic       alt;
    logic       ld;
    logic       st;
    logic       ar_i;
    logic       ar_r;
    logic       ar;
    logic       br;
    logic       lui;
    logic       auipc;
    logic       jal;
    logic       jalr;
    logic       fence;

    op    = w[6:2];
    f3    = w[14:12];
    f7    = w[31:25];
    alt   = (f7 == rv_isa_pkg::F7_ALT);
    full  = v && w != '0 && w[1:0] == rv_isa_pkg::OPC_FULL;
    ld    = full && op == rv_isa_pkg::OPC_LOAD && f3 != 3'd3 && f3 < 3'd6;
    st    = full && op == rv_isa_pkg::OPC_STORE && f3 < 3'd3;
    ar_i  = full && op == rv_isa_pkg::OPC_OP_IMM
            && ((f3 == 3'd1) ? f7 == rv_isa_pkg::F7_BASE
                             : (f3 != 3'd5 || f7 == rv_isa_pkg::F7_BASE || alt));
    ar_r  = full && op == rv_isa_pkg::OPC_OP
            && (f7 == rv_isa_pkg::F7_BASE || (alt && (f3 == 3'd0 || f3 == 3'd5)));
    ar    = ar_i || ar_r;
    br    = full && op == rv_isa_pkg::OPC_BRANCH && f3[2:1] != 2'b01;
    lui   = full && op == rv_isa_pkg::OPC_LUI;
    auipc = full && op == rv_isa_pkg::OPC_AUIPC;
    jal   = full && op == rv_isa_pkg::OPC_JAL;
    jalr  = full && op == rv_isa_pkg::OPC_JALR && f3 == 3'd0;
    fence = full && op == rv_isa_pkg::OPC_MISC_MEM && f3[2:1] == 2'b00;

    e = '0;
    e.valid          = v;
    e.inst_supported = !v || w == '0 || ld || st || ar || br
                       || lui || auipc || jal || jalr || fence;
    e.rd     = w[11:7];
    e.rs1    = lui ? 5'd0 : w[19:15];
    e.rs2    = w[24:20];
    e.funct3 = f3;
    e.imm_i  = (lui || auipc) ? {w[31:12], 12'h000}
             : st ? {{20{w[31]}}, w[31:25], w[11:7]} : {{20{w[31]}}, w[31:20]};
    e.imm_j  = jal ? {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0}
                   : {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};

    e.alu_ctrl.arith_add    = ld || st || (ar && f3 == 3'd0 && !(ar_r && alt));
    e.alu_ctrl.arith_sub    = ar_r && f3 == 3'd0 && alt;
    e.alu_ctrl.res_arith    = ld || st || (ar && f3 == 3'd0); // add, addi and sub
    e.alu_ctrl.cmp_eq       = br && f3[2:1] == 2'b00;
    e.alu_ctrl.cmp_lts      = (ar && f3 == 3'd2) || (br && f3[2:1] == 2'b10);
    e.alu_ctrl.cmp_ltu      = (ar && f3 == 3'd3) || (br && f3[2:1] == 2'b11);
    e.alu_ctrl.cmp_inversed = br && f3[0];
    e.alu_ctrl.res_cmp      = e.alu_ctrl.cmp_eq || e.alu_ctrl.cmp_lts || e.alu_ctrl.cmp_ltu;
    e.alu_ctrl.bits_xor     = ar && f3 == 3'd4;
    e.alu_ctrl.bits_or      = ar && f3 == 3'd6;
    e.alu_ctrl.bits_and     = ar && f3 == 3'd7;
    e.alu_ctrl.res_bits     = ar && f3 inside {3'd4, 3'd6, 3'd7};
    e.alu_ctrl.arith_shl    = ar && f3 == 3'd1;
    e.alu_ctrl.arith_shr    = ar && f3 == 3'd5;
    e.alu_ctrl.shift_arithmetical = ar && f3 == 3'd5 && alt;
    e.alu_ctrl.res_shift    = ar && (f3 == 3'd1 || f3 == 3'd5);

    e.op1_src.pc     = auipc || jal;
    e.op1_src.r      = !(auipc || jal);
    e.op2_src.j      = jal;
    e.op2_src.i      = jalr || ld || ar_i || lui || auipc || st;
    e.op2_src.r      = !(e.op2_src.j || e.op2_src.i);
    e.res_src.memory = ld;
    e.res_src.pc_p4  = jal || jalr;
    e.res_src.alu    = !(ld || jal || jalr);
    e.reg_write      = ld || ar || lui || auipc || jal || jalr;
    e.inst_jalr      = jalr;
    e.inst_jal       = jal;
    e.inst_branch    = br;
    e.inst_store     = st;
    e.pc             = pc;
    return e;
endfunction

`endif

// File: tb_rv_decode.sv
`timescale 1ns/1ps

module tb_rv_decode;

    localparam int N_DIRECTED = 70;
    localparam int N_RANDOM   = 300;
    localparam int MAX_CYCLES = N_DIRECTED + N_RANDOM + 50;

    logic                       i_clk;
    logic                       i_rst;
    logic                       i_valid;
    rv_decode_pkg::fetch_bus_t  i_fetch;
    rv_decode_pkg::decode_bus_t o_dec;
    rv_decode_pkg::decode_bus_t exp_q; // one-deep expectation
    logic                       rst_q;
    logic                       live    = 1'b0;
    logic [31:0]                lfsr    = 32'h4af7f6f7;
    logic [31:0]                next_pc = 32'h0000_1000;
    int                         cycles  = 0;
    int                         errors  = 0;
    int                         sent    = 0;
    int                         seen    = 0;

    `include "tb_rv_decode_model.svh"

    rv_decode #(
        .PC_W (32)
    ) DUT (
        .i_clk   (i_clk),
        .i_rst   (i_rst),
        .i_valid (i_valid),
        .i_fetch (i_fetch),
        .o_dec   (o_dec)
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    always @(posedge i_clk) begin
        exp_q  <= predict_decode(i_valid, i_fetch.instruction, i_fetch.pc);
        rst_q  <= i_rst;
        live   <= 1'b1;
        cycles <= cycles + 1;
        if (o_dec.valid) seen <= seen + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("run did not finish within %0d cycles", MAX_CYCLES);
            $display("sim failed");
            $finish;
        end
    end

    assert property (@(posedge i_clk) live && rst_q |->
            !o_dec.valid && !o_dec.reg_write && o_dec.alu_ctrl == '0)
        else begin
            errors++;
            $display("Fail o_dec.valid/reg_write/alu_ctrl in reset = %h %h %h",
                     $sampled(o_dec.valid), $sampled(o_dec.reg_write), $sampled(o_dec.alu_ctrl));
        end

    assert property (@(posedge i_clk) live && !rst_q |->
            o_dec.valid == exp_q.valid && o_dec.pc == exp_q.pc)
        else begin
            errors++;
            $display("Fail o_dec.valid/pc got %h %h exp %h %h", $sampled(o_dec.valid),
                     $sampled(o_dec.pc), $sampled(exp_q.valid), $sampled(exp_q.pc));
        end

    assert property (@(posedge i_clk) live && !rst_q |->
            {o_dec.rd, o_dec.rs1, o_dec.rs2, o_dec.funct3}
            == {exp_q.rd, exp_q.rs1, exp_q.rs2, exp_q.funct3})
        else begin
            errors++;
            $display("Fail o_dec.rd/rs1/rs2/funct3 got %h exp %h",
                     $sampled({o_dec.rd, o_dec.rs1, o_dec.rs2, o_dec.funct3}),
                     $sampled({exp_q.rd, exp_q.rs1, exp_q.rs2, exp_q.funct3}));
        end

    assert property (@(posedge i_clk) live && !rst_q |->
            o_dec.imm_i == exp_q.imm_i && o_dec.imm_j == exp_q.imm_j)
        else begin
            errors++;
            $display("Fail o_dec.imm_i/imm_j got %h %h exp %h %h", $sampled(o_dec.imm_i),
                     $sampled(o_dec.imm_j), $sampled(exp_q.imm_i), $sampled(exp_q.imm_j));
        end

    assert property (@(posedge i_clk) live && !rst_q |->
            {o_dec.alu_ctrl, o_dec.op1_src, o_dec.op2_src, o_dec.res_src}
            == {exp_q.alu_ctrl, exp_q.op1_src, exp_q.op2_src, exp_q.res_src})
        else begin
            errors++;
            $display("Fail o_dec.alu_ctrl/op1_src/op2_src/res_src got %h exp %h",
                     $sampled({o_dec.alu_ctrl, o_dec.op1_src, o_dec.op2_src, o_dec.res_src}),
                     $sampled({exp_q.alu_ctrl, exp_q.op1_src, exp_q.op2_src, exp_q.res_src}));
        end

    assert property (@(posedge i_clk) live && !rst_q |->
            {o_dec.inst_supported, o_dec.reg_write, o_dec.inst_jalr, o_dec.inst_jal,
             o_dec.inst_branch, o_dec.inst_store}
            == {exp_q.inst_supported, exp_q.reg_write, exp_q.inst_jalr, exp_q.inst_jal,
                exp_q.inst_branch, exp_q.inst_store})
        else begin
            errors++;
            $display("Fail o_dec.inst_supported/reg_write/jalr/jal/branch/store got %h exp %h",
                     $sampled({o_dec.inst_supported, o_dec.reg_write, o_dec.inst_jalr,
                               o_dec.inst_jal, o_dec.inst_branch, o_dec.inst_store}),
                     $sampled({exp_q.inst_supported, exp_q.reg_write, exp_q.inst_jalr,
                               exp_q.inst_jal, exp_q.inst_branch, exp_q.inst_store}));
        end

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    // one step per bit taken
    task automatic draw_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v[i] = lfsr[0];
        end
    endtask

    task automatic send_word(input logic [31:0] word);
        @(negedge i_clk);
        i_valid             = 1'b1;
        i_fetch.instruction = word;
        i_fetch.pc          = next_pc;
        next_pc             = next_pc + 32'd4;
        sent++;
    endtask

    task automatic send_op(input logic [6:0] f7, input logic [2:0] f3, input logic [4:0] opc);
        logic [31:0] r;
        draw_bits(15, r); // rd, rs1, rs2
        send_word(encode_word(f7, r[14:10], r[9:5], f3, r[4:0], opc));
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(negedge i_clk);
            i_valid = 1'b0;
        end
    endtask

    initial begin
        logic [31:0] w;
        logic [31:0] k;
        i_rst   = 1'b1;
        i_valid = 1'b1; // a live add word held through reset
        i_fetch = '0;
        i_fetch.instruction = encode_word(rv_isa_pkg::F7_BASE, 5'd2, 5'd1, 3'd0, 5'd3,
                                          rv_isa_pkg::OPC_OP);
        repeat (4) @(negedge i_clk);
        i_rst   = 1'b0;
        i_valid = 1'b0;
        idle_cycles(5);

        // every funct3 per opcode, back to back; invalid funct3 slots must come out unsupported
        for (int f = 0; f < 8; f++) begin
            send_op(rv_isa_pkg::F7_BASE, 3'(f), rv_isa_pkg::OPC_OP);
            send_op((f == 1 || f == 5) ? rv_isa_pkg::F7_BASE : {f[0], 6'h15}, 3'(f),
                    rv_isa_pkg::OPC_OP_IMM);
            send_op({f[1], 6'h2a}, 3'(f), rv_isa_pkg::OPC_LOAD);
            send_op({f[0], 6'h33}, 3'(f), rv_isa_pkg::OPC_STORE);
            send_op({f[2], 6'h0d}, 3'(f), rv_isa_pkg::OPC_BRANCH);
            send_op(7'h00, 3'(f), rv_isa_pkg::OPC_MISC_MEM);
            send_op({f[0], 6'h11}, 3'(f), rv_isa_pkg::OPC_JALR);
        end
        for (int s = 0; s < 2; s++) begin // both signs
            send_op({s[0], 6'h25}, 3'd2, rv_isa_pkg::OPC_LUI);
            send_op({s[0], 6'h19}, 3'd5, rv_isa_pkg::OPC_AUIPC);
            send_op({s[0], 6'h3c}, 3'd6, rv_isa_pkg::OPC_JAL);
        end
        send_op(rv_isa_pkg::F7_ALT, 3'd0, rv_isa_pkg::OPC_OP);     // sub
        send_op(rv_isa_pkg::F7_ALT, 3'd5, rv_isa_pkg::OPC_OP);     // sra
        send_op(rv_isa_pkg::F7_ALT, 3'd5, rv_isa_pkg::OPC_OP_IMM); // srai
        send_op(7'h01, 3'd0, rv_isa_pkg::OPC_OP);                  // bad funct7
        send_op(7'h00, 3'd0, rv_isa_pkg::OPC_SYSTEM);
        send_op(7'h00, 3'd1, rv_isa_pkg::OPC_SYSTEM);
        send_word(encode_word(7'h00, 5'd2, 5'd1, 3'd0, 5'd3, rv_isa_pkg::OPC_OP) ^ 32'h2);
        send_word('0); // bubble

        for (int n = 0; n < N_RANDOM; n++) begin
            draw_bits(32, w);
            draw_bits(2, k);
            if (k[1:0] != 2'b00) w[1:0] = 2'b11; // three in four are 32-bit words
            send_word(w);
        end
        idle_cycles(2);

        if (seen != sent) begin
            errors++;
            $display("expected %0d decoded outputs but counted %0d", sent, seen);
        end
        $display("errors %0d, outputs %0d of %0d sent", errors, seen, sent);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
